//--- filelist.f
verilog/eth_exerciser_pkg.sv
verilog/eth_stream_if.sv
verilog/csr_chan_if.sv
verilog/eth_csr_access.sv
verilog/eth_traffic_gen.sv
verilog/eth_traffic_chk.sv
verilog/eth_port_router.sv
verilog/eth_exerciser_top.sv
sim/tb_eth_exerciser.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_eth_exerciser -f filelist.f -Mdir obj_dir
./obj_dir/Vtb_eth_exerciser > sim.log 2>&1
cat sim.log
if grep -q "Finished with errors" sim.log; then
   exit 1
fi
grep -q "Finished with no errors" sim.log

//--- sim/tb_eth_exerciser.sv
// Testbench for the Ethernet traffic exerciser: register bus, loopback traffic and pattern checks
`timescale 1ns/1ps

module tb_eth_exerciser import eth_exerciser_pkg::*; ();

   localparam int          CLK_HALF     = 4;
   localparam int          RESET_CYCLES = 5;
   localparam int          EXP_WAITS    = 3;
   localparam int          WAIT_LIMIT   = 50;
   localparam int          BEAT_LIMIT   = 2000;
   localparam logic [16:0] LFSR_SEED    = 17'd96461;

   logic                    clk_sys;
   logic                    rst_sys;
   csr_addr_t               csr_addr;
   logic                    csr_read;
   logic                    csr_write;
   csr_data_t               csr_wdata;
   csr_data_t               csr_rdata;
   logic                    csr_rdata_valid;
   logic                    csr_waitrequest;
   logic [NUM_CHANNELS-1:0] tx_valid;
   eth_data_t               tx_data [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] tx_last;
   logic [NUM_CHANNELS-1:0] tx_ready;
   logic [NUM_CHANNELS-1:0] rx_valid;
   eth_data_t               rx_data [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] rx_last;
   logic [NUM_CHANNELS-1:0] tx_pause;

   // Transfers seen per port, and where the current run started counting
   int unsigned beat_cnt [NUM_CHANNELS];
   int unsigned beat_base [NUM_CHANNELS];
   int unsigned exp_len [NUM_CHANNELS];
   int unsigned exp_chan [NUM_CHANNELS];
   logic        drop_en;
   int unsigned drop_beat;
   int          errors;
   int          mon_errors;
   int          tests_passed;
   int          tests_failed;

   eth_exerciser_top eth_exerciser_top_inst (
      .clk_sys           (clk_sys),
      .rst_sys           (rst_sys),
      .i_csr_addr        (csr_addr),
      .i_csr_read        (csr_read),
      .i_csr_write       (csr_write),
      .i_csr_wdata       (csr_wdata),
      .o_csr_rdata       (csr_rdata),
      .o_csr_rdata_valid (csr_rdata_valid),
      .o_csr_waitrequest (csr_waitrequest),
      .o_tx_valid        (tx_valid),
      .o_tx_data         (tx_data),
      .o_tx_last         (tx_last),
      .i_tx_ready        (tx_ready),
      .i_rx_valid        (rx_valid),
      .i_rx_data         (rx_data),
      .i_rx_last         (rx_last),
      .o_tx_pause        (tx_pause)
   );

   // Loopback, a beat reaches the checker only when the port accepts it
   for (genvar p = 0; p < NUM_CHANNELS; p++) begin : g_loop
      logic hide;

      // One chosen beat on port 0 is held back from the checker
      assign hide        = (p == 0) && drop_en && (beat_cnt[p] == drop_beat);
      assign rx_valid[p] = tx_valid[p] & tx_ready[p] & ~hide;
      assign rx_data[p]  = tx_data[p];
      assign rx_last[p]  = tx_last[p];
   end

   initial begin
      clk_sys = 1'b0;
      forever begin
         #CLK_HALF clk_sys = ~clk_sys;
      end
   end

   function automatic logic [16:0] lfsr_next(input logic [16:0] state);
      // Taps at 17 and 14
      return {state[15:0], state[16] ^ state[13]};
   endfunction

   // Expected beat from sequence number, channel id and beat index
   function automatic eth_data_t expected_beat(input int unsigned seq, input int unsigned chan,
                                               input int unsigned idx);
      return {seq[15:0], chan[7:0], idx[7:0]};
   endfunction

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual, inout int err_count);
      if (expected !== actual) begin
         $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
         err_count++;
      end
   endtask

   task automatic abort_timeout(input string what);
      $display("Timeout while waiting for %s", what);
      $display("Finished with errors");
      $finish;
   endtask

   // Random back-pressure, one LFSR step per ready bit
   initial begin : ready_gen
      logic [16:0] lfsr;
      lfsr = LFSR_SEED;
      tx_ready <= '0;
      forever begin
         @(posedge clk_sys);
         for (int p = 0; p < NUM_CHANNELS; p++) begin
            lfsr = lfsr_next(lfsr);
            tx_ready[p] <= lfsr[0];
         end
      end
   end

   initial begin : tx_monitor
      int unsigned k;
      int unsigned idx;
      mon_errors = 0;
      for (int p = 0; p < NUM_CHANNELS; p++) begin
         beat_cnt[p] <= 0;
      end
      forever begin
         @(posedge clk_sys);
         for (int p = 0; p < NUM_CHANNELS; p++) begin
            if (!rst_sys && tx_valid[p] && tx_ready[p]) begin
               k   = beat_cnt[p] - beat_base[p];
               idx = k % exp_len[p];
               compare($sformatf("tx%0d_data", p),
                       expected_beat(k / exp_len[p], exp_chan[p], idx), tx_data[p], mon_errors);
               compare($sformatf("tx%0d_last", p), 32'(idx == exp_len[p] - 1),
                       32'(tx_last[p]), mon_errors);
               beat_cnt[p] <= beat_cnt[p] + 1;
            end
         end
      end
   end

   task automatic hold_reset();
      rst_sys <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_sys);
      rst_sys <= 1'b0;
   endtask

   // Request is held until waitrequest drops, read data follows one cycle later
   task automatic bus_access(input logic is_write, input csr_addr_t addr,
                             input csr_data_t wdata, output csr_data_t rdata);
      int waits;
      int n;
      waits = 0;
      n     = 0;
      rdata = '0;
      @(posedge clk_sys);
      csr_addr  <= addr;
      csr_wdata <= wdata;
      csr_write <= is_write;
      csr_read  <= !is_write;
      do begin
         @(posedge clk_sys);
         n++;
         if (csr_waitrequest) begin
            waits++;
         end
      end while (csr_waitrequest && n < WAIT_LIMIT);
      if (csr_waitrequest) begin
         abort_timeout("waitrequest to drop");
      end
      csr_write <= 1'b0;
      csr_read  <= 1'b0;
      compare($sformatf("wait_cycles_0x%04h", addr), 32'(EXP_WAITS), 32'(waits), errors);
      if (!is_write) begin
         compare("rdata_valid_early", 32'd0, 32'(csr_rdata_valid), errors);
         @(posedge clk_sys);
         compare("rdata_valid", 32'd1, 32'(csr_rdata_valid), errors);
         rdata = csr_rdata;
      end
   endtask

   task automatic bus_write(input csr_addr_t addr, input csr_data_t wdata);
      csr_data_t unused_rd;
      bus_access(1'b1, addr, wdata, unused_rd);
   endtask

   task automatic read_check(input string name, input csr_addr_t addr, input csr_data_t expected);
      csr_data_t rd;
      bus_access(1'b0, addr, '0, rd);
      compare(name, expected, rd, errors);
   endtask

   // Monitor expectations for the next run on a port
   task automatic arm_port(input int p, input int unsigned len, input int unsigned chan);
      beat_base[p] = beat_cnt[p];
      exp_len[p]   = len;
      exp_chan[p]  = chan;
   endtask

   task automatic wait_beats(input int p, input int unsigned n, input string what);
      int cycles;
      cycles = 0;
      while (beat_cnt[p] < beat_base[p] + n && cycles < BEAT_LIMIT) begin
         @(posedge clk_sys);
         cycles++;
      end
      if (beat_cnt[p] < beat_base[p] + n) begin
         abort_timeout(what);
      end
   endtask

   task automatic end_test(input string name, input int mark);
      if (errors + mon_errors == mark) begin
         $display("PASS %s", name);
         tests_passed++;
      end else begin
         $display("FAIL %s", name);
         tests_failed++;
      end
   endtask

   initial begin : test_seq
      int          mark;
      int unsigned other_base;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      drop_en      = 1'b0;
      drop_beat    = 0;
      for (int p = 0; p < NUM_CHANNELS; p++) begin
         beat_base[p] = 0;
         exp_len[p]   = 1;
         exp_chan[p]  = p;
      end
      csr_addr  <= '0;
      csr_read  <= 1'b0;
      csr_write <= 1'b0;
      csr_wdata <= '0;
      hold_reset();

      mark = errors + mon_errors;
      bus_write(REG_PORT_SEL, 32'd0);
      bus_write(REG_PKT_LEN, 32'd5);
      bus_write(REG_PKT_COUNT, 32'd7);
      bus_write(REG_PORT_SEL, 32'd1);
      bus_write(REG_PKT_LEN, 32'd9);
      bus_write(REG_PKT_COUNT, 32'd2);
      read_check("ch1_pkt_len", REG_PKT_LEN, 32'd9);
      read_check("ch1_pkt_count", REG_PKT_COUNT, 32'd2);
      read_check("port_sel", REG_PORT_SEL, 32'd1);
      bus_write(REG_PORT_SEL, 32'd0);
      read_check("ch0_pkt_len", REG_PKT_LEN, 32'd5);
      read_check("ch0_pkt_count", REG_PKT_COUNT, 32'd7);
      end_test("register_readback", mark);

      mark = errors + mon_errors;
      bus_write(REG_PKT_LEN, 32'd4);
      bus_write(REG_PKT_COUNT, 32'd3);
      arm_port(0, 4, 0);
      other_base = beat_cnt[1];
      bus_write(REG_START, 32'd1);
      wait_beats(0, 12, "beats on port 0");
      compare("port1_beats", other_base, beat_cnt[1], errors);
      read_check("ch0_tx_sent", REG_TX_SENT, 32'd3);
      end_test("generation_backpressure", mark);

      mark = errors + mon_errors;
      read_check("ch0_rx_good", REG_RX_GOOD, 32'd3);
      read_check("ch0_rx_bad", REG_RX_BAD, 32'd0);
      end_test("checker_good_count", mark);

      // Second beat of the first packet never reaches the checker
      mark = errors + mon_errors;
      arm_port(0, 4, 0);
      drop_beat = beat_base[0] + 1;
      drop_en   = 1'b1;
      bus_write(REG_START, 32'd1);
      wait_beats(0, 12, "beats on port 0 with a dropped beat");
      drop_en = 1'b0;
      read_check("ch0_rx_bad", REG_RX_BAD, 32'd1);
      read_check("ch0_rx_good", REG_RX_GOOD, 32'd5);
      end_test("error_detection", mark);

      mark = errors + mon_errors;
      bus_write(REG_GLOBAL_CTL, 32'h0000_0001);
      arm_port(1, 4, 0);
      other_base = beat_cnt[0];
      bus_write(REG_START, 32'd1);
      wait_beats(1, 12, "swapped beats on port 1");
      compare("port0_beats", other_base, beat_cnt[0], errors);
      bus_write(REG_PORT_SEL, 32'd1);
      read_check("ch1_rx_good", REG_RX_GOOD, 32'd3);
      read_check("ch1_rx_bad", REG_RX_BAD, 32'd0);
      end_test("cross_port_routing", mark);

      // Pause bit for channel 1 only, swap cleared at the same time
      mark = errors + mon_errors;
      bus_write(REG_GLOBAL_CTL, 32'h0000_0200);
      @(posedge clk_sys);
      compare("tx_pause", 32'h2, 32'(tx_pause), errors);
      hold_reset();
      @(posedge clk_sys);
      compare("tx_pause_after_reset", 32'h0, 32'(tx_pause), errors);
      read_check("global_ctl_after_reset", REG_GLOBAL_CTL, 32'h0);
      end_test("pause_outputs", mark);

      $display("Tests: %0d passed, %0d failed, %0d check errors",
               tests_passed, tests_failed, errors + mon_errors);
      if (errors + mon_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- verilog/eth_exerciser_top.sv
// Top level of the Ethernet traffic exerciser, register bus and streams on plain ports
`timescale 1ns/1ps

module eth_exerciser_top import eth_exerciser_pkg::*; (
   input  logic                    clk_sys,
   input  logic                    rst_sys,
   // Register bus
   input  csr_addr_t               i_csr_addr,
   input  logic                    i_csr_read,
   input  logic                    i_csr_write,
   input  csr_data_t               i_csr_wdata,
   output csr_data_t               o_csr_rdata,
   output logic                    o_csr_rdata_valid,
   output logic                    o_csr_waitrequest,
   // Transmit ports
   output logic [NUM_CHANNELS-1:0] o_tx_valid,
   output eth_data_t               o_tx_data [NUM_CHANNELS],
   output logic [NUM_CHANNELS-1:0] o_tx_last,
   input  logic [NUM_CHANNELS-1:0] i_tx_ready,
   // Receive ports
   input  logic [NUM_CHANNELS-1:0] i_rx_valid,
   input  eth_data_t               i_rx_data [NUM_CHANNELS],
   input  logic [NUM_CHANNELS-1:0] i_rx_last,
   output logic [NUM_CHANNELS-1:0] o_tx_pause
);

   logic         port_swap_en;
   eth_stream_if gen_st [NUM_CHANNELS] ();
   // Generators on 0..NUM_CHANNELS-1, checkers above them
   csr_chan_if   chan_csr [NUM_CSR_PORTS] ();

   eth_csr_access eth_csr_access_inst (
      .clk_sys           (clk_sys),
      .rst_sys           (rst_sys),
      .i_csr_addr        (i_csr_addr),
      .i_csr_read        (i_csr_read),
      .i_csr_write       (i_csr_write),
      .i_csr_wdata       (i_csr_wdata),
      .o_csr_rdata       (o_csr_rdata),
      .o_csr_rdata_valid (o_csr_rdata_valid),
      .o_csr_waitrequest (o_csr_waitrequest),
      .chan_csr          (chan_csr),
      .o_port_swap_en    (port_swap_en),
      .o_tx_pause        (o_tx_pause)
   );

   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
      eth_traffic_gen eth_traffic_gen_inst (
         .clk_sys   (clk_sys),
         .rst_sys   (rst_sys),
         .csr       (chan_csr[ch]),
         .tx        (gen_st[ch]),
         .i_chan_id (chan_id_t'(ch))
      );

      eth_traffic_chk eth_traffic_chk_inst (
         .clk_sys    (clk_sys),
         .rst_sys    (rst_sys),
         .csr        (chan_csr[NUM_CHANNELS + ch]),
         .i_rx_valid (i_rx_valid[ch]),
         .i_rx_data  (i_rx_data[ch]),
         .i_rx_last  (i_rx_last[ch])
      );
   end

   eth_port_router eth_port_router_inst (
      .clk_sys        (clk_sys),
      .rst_sys        (rst_sys),
      .i_port_swap_en (port_swap_en),
      .gen_st         (gen_st),
      .o_tx_valid     (o_tx_valid),
      .o_tx_data      (o_tx_data),
      .o_tx_last      (o_tx_last),
      .i_tx_ready     (i_tx_ready)
   );

endmodule

//--- verilog/eth_port_router.sv
// Cross-port routing of generator streams to the transmit ports, switched between frames
`timescale 1ns/1ps

module eth_port_router import eth_exerciser_pkg::*; (
   input  logic                    clk_sys,
   input  logic                    rst_sys,
   input  logic                    i_port_swap_en,
   eth_stream_if.sink              gen_st [NUM_CHANNELS],
   output logic [NUM_CHANNELS-1:0] o_tx_valid,
   output eth_data_t               o_tx_data [NUM_CHANNELS],
   output logic [NUM_CHANNELS-1:0] o_tx_last,
   input  logic [NUM_CHANNELS-1:0] i_tx_ready
);

   logic                    swap_q;
   logic [NUM_CHANNELS-1:0] in_frame;
   logic [NUM_CHANNELS-1:0] port_busy;
   logic [NUM_CHANNELS-1:0] gen_valid;
   logic [NUM_CHANNELS-1:0] gen_last;
   eth_data_t               gen_data [NUM_CHANNELS];

   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_route
      // Half-way shift is its own inverse for an even channel count
      localparam int PEER = (ch + NUM_CHANNELS / 2) % NUM_CHANNELS;

      assign gen_valid[ch]    = gen_st[ch].valid;
      assign gen_last[ch]     = gen_st[ch].last;
      assign gen_data[ch]     = gen_st[ch].data;
      assign gen_st[ch].ready = swap_q ? i_tx_ready[PEER] : i_tx_ready[ch];

      assign o_tx_valid[ch] = swap_q ? gen_valid[PEER] : gen_valid[ch];
      assign o_tx_last[ch]  = swap_q ? gen_last[PEER]  : gen_last[ch];
      assign o_tx_data[ch]  = swap_q ? gen_data[PEER]  : gen_data[ch];

      // A pending first beat also pins the mapping
      assign port_busy[ch] = in_frame[ch] | o_tx_valid[ch];
   end

   always_ff @(posedge clk_sys) begin
      if (rst_sys) begin
         in_frame <= '0;
         swap_q   <= 1'b0;
      end else begin
         for (int p = 0; p < NUM_CHANNELS; p++) begin
            if (o_tx_valid[p] && i_tx_ready[p]) begin
               in_frame[p] <= ~o_tx_last[p];
            end
         end
         if (port_busy == '0) begin
            swap_q <= i_port_swap_en;
         end
      end
   end

   // A port inside a frame keeps its source, so its valid stays high until the last beat
   assert property (@(posedge clk_sys) disable iff (rst_sys) (in_frame & ~o_tx_valid) == '0);

endmodule

//--- verilog/eth_traffic_chk.sv
// Per-channel receive checker that counts good and bad packets against the beat pattern
`timescale 1ns/1ps

module eth_traffic_chk import eth_exerciser_pkg::*; (
   input  logic      clk_sys,
   input  logic      rst_sys,
   csr_chan_if.chan  csr,
   input  logic      i_rx_valid,
   input  eth_data_t i_rx_data,
   input  logic      i_rx_last
);

   beat_cnt_t exp_beat;
   pkt_cnt_t  prev_seq;
   logic      have_prev;
   logic      pkt_err;
   logic      beat_err;
   pkt_cnt_t  good_cnt;
   pkt_cnt_t  bad_cnt;
   beat_cnt_t rx_beat;
   pkt_cnt_t  rx_seq;
   logic      start;

   assign rx_beat = i_rx_data[BEAT_LSB +: BEAT_CNT_W];
   assign rx_seq  = i_rx_data[SEQ_LSB +: PKT_CNT_W];
   assign start   = csr.write & (csr.addr == REG_START) & csr.wdata[START_BIT];

   // First packet after a start may carry any sequence number
   assign beat_err = (rx_beat != exp_beat) | (have_prev & (rx_seq != prev_seq + 1'b1));

   always_ff @(posedge clk_sys) begin
      if (rst_sys) begin
         exp_beat  <= '0;
         prev_seq  <= '0;
         have_prev <= 1'b0;
         pkt_err   <= 1'b0;
         good_cnt  <= '0;
         bad_cnt   <= '0;
      end else if (start) begin
         exp_beat  <= '0;
         have_prev <= 1'b0;
         pkt_err   <= 1'b0;
      end else if (i_rx_valid && i_rx_last) begin
         // Verdict on the last beat, then resync for the next packet
         if (pkt_err || beat_err) begin
            bad_cnt <= bad_cnt + 1'b1;
         end else begin
            good_cnt <= good_cnt + 1'b1;
         end
         prev_seq  <= rx_seq;
         have_prev <= 1'b1;
         exp_beat  <= '0;
         pkt_err   <= 1'b0;
      end else if (i_rx_valid) begin
         exp_beat <= exp_beat + 1'b1;
         pkt_err  <= pkt_err | beat_err;
      end
   end

   always_comb begin
      csr.rdata = '0;
      if (csr.read) begin
         case (csr.addr)
            REG_RX_GOOD: csr.rdata = csr_data_t'(good_cnt);
            REG_RX_BAD:  csr.rdata = csr_data_t'(bad_cnt);
            default:     csr.rdata = '0;
         endcase
      end
   end

endmodule

//--- verilog/eth_traffic_gen.sv
// Per-channel packet generator with length, count, start and sent-count registers
`timescale 1ns/1ps

module eth_traffic_gen import eth_exerciser_pkg::*; (
   input  logic         clk_sys,
   input  logic         rst_sys,
   csr_chan_if.chan     csr,
   eth_stream_if.source tx,
   input  chan_id_t     i_chan_id
);

   gen_state_t state;
   beat_cnt_t  pkt_len;
   pkt_cnt_t   pkt_count;
   pkt_cnt_t   sent_cnt;
   beat_cnt_t  beat_idx;
   logic       start;
   logic       beat_xfer;
   logic       beat_last;

   assign start     = csr.write & (csr.addr == REG_START) & csr.wdata[START_BIT];
   assign beat_xfer = tx.valid & tx.ready;
   assign beat_last = (beat_idx == pkt_len - 1'b1);

   // Sent count doubles as the sequence number of the packet in flight
   assign tx.valid = (state == GEN_SEND);
   assign tx.last  = beat_last;
   assign tx.data  = {sent_cnt, beat_cnt_t'(i_chan_id), beat_idx};

   always_ff @(posedge clk_sys) begin
      if (rst_sys) begin
         pkt_len   <= '0;
         pkt_count <= '0;
      end else if (csr.write) begin
         if (csr.addr == REG_PKT_LEN) begin
            pkt_len <= csr.wdata[BEAT_CNT_W-1:0];
         end
         if (csr.addr == REG_PKT_COUNT) begin
            pkt_count <= csr.wdata[PKT_CNT_W-1:0];
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_sys) begin
         state    <= GEN_IDLE;
         sent_cnt <= '0;
         beat_idx <= '0;
      end else begin
         case (state)
            GEN_IDLE: begin
               // Start is only taken between runs
               if (start) begin
                  sent_cnt <= '0;
                  beat_idx <= '0;
                  if (pkt_count != '0) begin
                     state <= GEN_SEND;
                  end
               end
            end
            GEN_SEND: begin
               if (beat_xfer && beat_last) begin
                  beat_idx <= '0;
                  sent_cnt <= sent_cnt + 1'b1;
                  if (sent_cnt + 1'b1 >= pkt_count) begin
                     state <= GEN_IDLE;
                  end
               end else if (beat_xfer) begin
                  beat_idx <= beat_idx + 1'b1;
               end
            end
            default: state <= GEN_IDLE;
         endcase
      end
   end

   always_comb begin
      csr.rdata = '0;
      if (csr.read) begin
         case (csr.addr)
            REG_PKT_LEN:   csr.rdata = csr_data_t'(pkt_len);
            REG_PKT_COUNT: csr.rdata = csr_data_t'(pkt_count);
            REG_TX_SENT:   csr.rdata = csr_data_t'(sent_cnt);
            default:       csr.rdata = '0;
         endcase
      end
   end

   // Stalled beat is held until the transmit port takes it
   assert property (@(posedge clk_sys) disable iff (rst_sys)
      (tx.valid && !tx.ready) |=> (tx.valid && $stable(tx.data) && $stable(tx.last)));

endmodule

//--- verilog/eth_csr_access.sv
// Register bus front end: waitrequest delay, global registers and steering to the channels
`timescale 1ns/1ps

module eth_csr_access import eth_exerciser_pkg::*; (
   input  logic                    clk_sys,
   input  logic                    rst_sys,
   input  csr_addr_t               i_csr_addr,
   input  logic                    i_csr_read,
   input  logic                    i_csr_write,
   input  csr_data_t               i_csr_wdata,
   output csr_data_t               o_csr_rdata,
   output logic                    o_csr_rdata_valid,
   output logic                    o_csr_waitrequest,
   csr_chan_if.host                chan_csr [NUM_CSR_PORTS],
   output logic                    o_port_swap_en,
   output logic [NUM_CHANNELS-1:0] o_tx_pause
);

   csr_state_t            state;
   logic [WAIT_CNT_W-1:0] wait_cnt;
   logic                  req;
   logic                  done;
   logic                  is_chan;
   chan_id_t              port_sel;
   csr_data_t             global_rdata;
   csr_data_t             chan_rdata [NUM_CSR_PORTS];
   csr_data_t             chan_rdata_or;

   assign req     = i_csr_read | i_csr_write;
   assign done    = (state == CSR_DONE);
   assign is_chan = (i_csr_addr >= CHAN_REG_BASE);

   // High from the first request cycle, low only in the completing cycle
   assign o_csr_waitrequest = (state == CSR_WAIT) | ((state == CSR_IDLE) & req);

   always_ff @(posedge clk_sys) begin
      if (rst_sys) begin
         state    <= CSR_IDLE;
         wait_cnt <= '0;
      end else begin
         case (state)
            CSR_IDLE: begin
               if (req) begin
                  state    <= CSR_WAIT;
                  wait_cnt <= WAIT_CNT_W'(1);
               end
            end
            CSR_WAIT: begin
               if (wait_cnt == WAIT_CNT_W'(CSR_WAIT_CYCLES - 1)) begin
                  state <= CSR_DONE;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            default: state <= CSR_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_sys) begin
         o_port_swap_en <= 1'b0;
         o_tx_pause     <= '0;
         port_sel       <= '0;
      end else if (done && i_csr_write && !is_chan) begin
         case (i_csr_addr)
            REG_GLOBAL_CTL: begin
               o_port_swap_en <= i_csr_wdata[CTL_SWAP_BIT];
               o_tx_pause     <= i_csr_wdata[CTL_PAUSE_LSB +: NUM_CHANNELS];
            end
            REG_PORT_SEL: port_sel <= i_csr_wdata[CHAN_ID_W-1:0];
            default: ;
         endcase
      end
   end

   always_comb begin
      global_rdata = '0;
      case (i_csr_addr)
         REG_GLOBAL_CTL: begin
            global_rdata[CTL_SWAP_BIT]                  = o_port_swap_en;
            global_rdata[CTL_PAUSE_LSB +: NUM_CHANNELS] = o_tx_pause;
         end
         REG_PORT_SEL: global_rdata[CHAN_ID_W-1:0] = port_sel;
         default: ;
      endcase
   end

   // Ports i and i+NUM_CHANNELS belong to the same channel
   for (genvar i = 0; i < NUM_CSR_PORTS; i++) begin : g_port
      localparam chan_id_t CH = chan_id_t'(i % NUM_CHANNELS);
      logic sel;

      assign sel                = done & is_chan & (port_sel == CH);
      assign chan_csr[i].addr   = i_csr_addr;
      assign chan_csr[i].wdata  = i_csr_wdata;
      assign chan_csr[i].write  = sel & i_csr_write;
      assign chan_csr[i].read   = sel & i_csr_read;
      assign chan_rdata[i]      = chan_csr[i].rdata;
   end

   // Unselected ports return zero, so an OR picks the addressed one
   always_comb begin
      chan_rdata_or = '0;
      for (int i = 0; i < NUM_CSR_PORTS; i++) begin
         chan_rdata_or = chan_rdata_or | chan_rdata[i];
      end
   end

   always_ff @(posedge clk_sys) begin
      if (rst_sys) begin
         o_csr_rdata_valid <= 1'b0;
      end else begin
         o_csr_rdata_valid <= done & i_csr_read;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (done && i_csr_read) begin
         o_csr_rdata <= is_chan ? chan_rdata_or : global_rdata;
      end
   end

   // Bus master issues one kind of access at a time
   assert property (@(posedge clk_sys) disable iff (rst_sys) !(i_csr_read && i_csr_write));

endmodule

//--- verilog/csr_chan_if.sv
// Register access port from the CSR block to one channel's generator or checker
`timescale 1ns/1ps

interface csr_chan_if import eth_exerciser_pkg::*; ();

   csr_addr_t addr;
   logic      write;
   logic      read;
   csr_data_t wdata;
   csr_data_t rdata;

   // Strobes last one cycle, rdata comes back in the same cycle
   modport host (
      output addr, write, read, wdata,
      input  rdata
   );

   modport chan (
      input  addr, write, read, wdata,
      output rdata
   );

endinterface

//--- verilog/eth_stream_if.sv
// Valid/ready packet stream between the generators, the port router and the transmit ports
`timescale 1ns/1ps

interface eth_stream_if import eth_exerciser_pkg::*; ();

   logic      valid;
   eth_data_t data;
   logic      last;
   logic      ready;

   // Beat moves when valid and ready are both high
   modport source (
      output valid, data, last,
      input  ready
   );

   modport sink (
      input  valid, data, last,
      output ready
   );

endinterface

//--- verilog/eth_exerciser_pkg.sv
// Widths, types, register map and FSM encodings shared by all exerciser RTL, imported per module
package eth_exerciser_pkg;

   localparam int NUM_CHANNELS    = 2;
   // Each channel has one register port for its generator and one for its checker
   localparam int NUM_CSR_PORTS   = 2 * NUM_CHANNELS;
   localparam int CSR_ADDR_W      = 16;
   localparam int CSR_DATA_W      = 32;
   localparam int ETH_DATA_W      = 32;
   localparam int BEAT_CNT_W      = 8;
   localparam int PKT_CNT_W       = 16;
   localparam int CHAN_ID_W       = 1;
   localparam int CSR_WAIT_CYCLES = 3;
   localparam int WAIT_CNT_W      = $clog2(CSR_WAIT_CYCLES);

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [CSR_DATA_W-1:0] csr_data_t;
   typedef logic [ETH_DATA_W-1:0] eth_data_t;
   typedef logic [BEAT_CNT_W-1:0] beat_cnt_t;
   typedef logic [PKT_CNT_W-1:0]  pkt_cnt_t;
   typedef logic [CHAN_ID_W-1:0]  chan_id_t;

   // Global registers
   localparam csr_addr_t REG_GLOBAL_CTL = 16'h0000;
   localparam csr_addr_t REG_PORT_SEL   = 16'h0001;
   // Channel registers, steered by the port select
   localparam csr_addr_t REG_PKT_LEN    = 16'h0010;
   localparam csr_addr_t REG_PKT_COUNT  = 16'h0011;
   localparam csr_addr_t REG_START      = 16'h0012;
   localparam csr_addr_t REG_TX_SENT    = 16'h0013;
   localparam csr_addr_t REG_RX_GOOD    = 16'h0014;
   localparam csr_addr_t REG_RX_BAD     = 16'h0015;
   localparam csr_addr_t CHAN_REG_BASE  = REG_PKT_LEN;

   localparam int CTL_SWAP_BIT  = 0;
   localparam int CTL_PAUSE_LSB = 8;
   localparam int START_BIT     = 0;

   // Beat layout is sequence, channel id, beat index
   localparam int SEQ_LSB  = 16;
   localparam int BEAT_LSB = 0;

   typedef enum logic {GEN_IDLE, GEN_SEND} gen_state_t;
   typedef enum logic [1:0] {CSR_IDLE, CSR_WAIT, CSR_DONE} csr_state_t;

endpackage
